//--- common/i2c_pkg.sv
package i2c_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] reg_addr_t;
	typedef logic [31:0] dly_t;
	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;
	typedef logic [5:0]  cmd_flags_t;

	// byte command flags, may be combined
	localparam cmd_flags_t CMD_WR   = 6'b000001;
	localparam cmd_flags_t CMD_STA  = 6'b000010;
	localparam cmd_flags_t CMD_RD   = 6'b000100;
	localparam cmd_flags_t CMD_STO  = 6'b001000;
	localparam cmd_flags_t CMD_ACK  = 6'b010000;
	localparam cmd_flags_t CMD_NACK = 6'b100000;

	localparam apb_addr_t REG_CTRL   = 8'h00;
	localparam apb_addr_t REG_DEV    = 8'h04;
	localparam apb_addr_t REG_ADDR   = 8'h08;
	localparam apb_addr_t REG_WDATA  = 8'h0C;
	localparam apb_addr_t REG_DLY    = 8'h10;
	localparam apb_addr_t REG_STATUS = 8'h14;
	localparam apb_addr_t REG_RDATA  = 8'h18;

	typedef struct packed {
		apb_addr_t paddr;
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic      wr_start;
		logic      rd_start;
		logic      addr_mode; // 1: two address bytes
		byte_t     dev_id;
		reg_addr_t reg_addr;
		byte_t     wr_data;
		dly_t      dly;
	} xfer_req_t;

	typedef struct packed {
		logic  busy;
		logic  done;
		logic  ack_err;
		byte_t rd_data;
	} xfer_rsp_t;

	typedef struct packed {
		logic       go;
		cmd_flags_t flags;
		byte_t      tx;
	} byte_cmd_t;

	typedef struct packed {
		logic  done;
		logic  ack_err; // slave left SDA high
		byte_t rx;
	} byte_rsp_t;

	typedef struct packed {
		logic scl;
		logic sda_oe; // 1 pulls SDA low
	} i2c_pins_t;

endpackage

//--- i2c_control/i2c_bit_shift.sv
`timescale 1ns/100ps

module i2c_bit_shift
	import i2c_pkg::*;
#(
	parameter int SCL_DIV = 4
)
(
	input  logic      Clk,
	input  logic      Rst_n,
	input  byte_cmd_t byte_cmd,
	output byte_rsp_t byte_rsp,
	output i2c_pins_t pins,
	input  logic      sda_in
);

	localparam int DW = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;

	typedef enum logic [2:0] {
		IDLE,
		START,
		DATA,
		ACK,
		STOP
	} state_t;

	state_t     state;
	logic [DW-1:0] div_cnt;
	logic [1:0] qtr;     // quarter within the current bit
	logic [2:0] bit_cnt;
	byte_t      sh;
	cmd_flags_t flags_q;
	logic       ack_err;
	logic       done;
	logic       tick;
	logic       sample;
	logic       qtr_end;
	logic       is_wr;
	logic       is_rd;
	logic       do_sto;
	logic       do_ack;
	logic       scl_high;
	logic       hold_scl;    // SCL kept low between bytes of a frame

	assign tick    = (state != IDLE) && (div_cnt == DW'(SCL_DIV - 1));
	assign sample  = tick && (qtr == 2'd1);
	assign qtr_end = tick && (qtr == 2'd3);

	assign is_wr  = (flags_q & CMD_WR) != '0;
	assign is_rd  = (flags_q & CMD_RD) != '0;
	assign do_sto = (flags_q & CMD_STO) != '0;
	assign do_ack = ((flags_q & CMD_ACK) != '0) && ((flags_q & CMD_NACK) == '0);

	// SCL high in the middle two quarters
	assign scl_high = qtr[0] ^ qtr[1];

	always_ff @(posedge Clk or negedge Rst_n)
	begin
		if (!Rst_n)
		begin
			state    <= IDLE;
			div_cnt  <= '0;
			qtr      <= '0;
			bit_cnt  <= '0;
			flags_q  <= '0;
			ack_err  <= 1'b0;
			done     <= 1'b0;
			hold_scl <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (state == IDLE)
			begin
				div_cnt <= '0;
				qtr     <= '0;
				if (byte_cmd.go)
				begin
					flags_q <= byte_cmd.flags;
					bit_cnt <= 3'd7;
					ack_err <= 1'b0;
					state   <= ((byte_cmd.flags & CMD_STA) != '0) ? START : DATA;
				end
			end
			else
			begin
				div_cnt <= tick ? '0 : div_cnt + 1'b1;
				if (tick)
					qtr <= qtr + 2'd1;
				if (sample && state == ACK && is_wr)
					ack_err <= sda_in;
				if (qtr_end)
				begin
					case (state)
						START: state <= DATA;
						DATA:
						begin
							if (bit_cnt == 3'd0)
								state <= ACK;
							else
								bit_cnt <= bit_cnt - 3'd1;
						end
						ACK:
						begin
							if (do_sto)
								state <= STOP;
							else
							begin
								done     <= 1'b1;
								hold_scl <= 1'b1;
								state    <= IDLE;
							end
						end
						default:
						begin
							done     <= 1'b1; // end of stop condition
							hold_scl <= 1'b0;
							state    <= IDLE;
						end
					endcase
				end
			end
		end
	end

	// shift out MSB first, or sample on the high half of SCL
	always_ff @(posedge Clk)
	begin
		if (state == IDLE && byte_cmd.go)
			sh <= byte_cmd.tx;
		else if (state == DATA && is_rd && sample)
			sh <= {sh[6:0], sda_in};
		else if (state == DATA && !is_rd && qtr_end)
			sh <= {sh[6:0], 1'b0};
	end

	always_comb
	begin
		pins.scl    = 1'b1;
		pins.sda_oe = 1'b0;
		case (state)
			START:
			begin
				pins.scl    = scl_high;
				pins.sda_oe = qtr[1]; // SDA falls while SCL high
			end
			DATA:
			begin
				pins.scl    = scl_high;
				pins.sda_oe = !is_rd && !sh[7];
			end
			ACK:
			begin
				pins.scl    = scl_high;
				pins.sda_oe = is_rd && do_ack;
			end
			STOP:
			begin
				pins.scl    = (qtr != 2'd0);
				pins.sda_oe = !qtr[1]; // SDA rises while SCL high
			end
			default:
				pins.scl = !hold_scl;
		endcase
	end

	assign byte_rsp.done    = done;
	assign byte_rsp.ack_err = ack_err;
	assign byte_rsp.rx      = sh;

endmodule

//--- i2c_control/i2c_control.sv
`timescale 1ns/100ps

module i2c_control
	import i2c_pkg::*;
(
	input  logic      Clk,
	input  logic      Rst_n,
	input  xfer_req_t xfer_req,
	output xfer_rsp_t xfer_rsp,
	output byte_cmd_t byte_cmd,
	input  byte_rsp_t byte_rsp
);

	typedef enum logic [2:0] {
		IDLE,
		ISSUE,
		WAIT_BYTE,
		FINISH,
		WAIT_DLY
	} state_t;

	state_t     state;
	logic [2:0] idx;     // byte index within the frame
	logic       is_rd;
	logic       ack_err;
	logic       done;
	byte_t      rd_data;
	dly_t       dly_cnt;
	logic       last_byte;
	cmd_flags_t next_flags;
	byte_t      next_tx;

	assign last_byte = is_rd ? (idx == 3'd4) : (idx == 3'd3);

	// command for the current byte index
	always_comb
	begin
		next_flags = CMD_WR;
		next_tx    = '0;
		case (idx)
			3'd0:
			begin
				next_flags = CMD_STA | CMD_WR;
				next_tx    = xfer_req.dev_id;
			end
			3'd1:
				next_tx = xfer_req.reg_addr[15:8];
			3'd2:
				next_tx = xfer_req.reg_addr[7:0];
			3'd3:
			begin
				if (is_rd)
				begin
					next_flags = CMD_STA | CMD_WR; // repeated start
					next_tx    = xfer_req.dev_id | 8'h01;
				end
				else
				begin
					next_flags = CMD_WR | CMD_STO;
					next_tx    = xfer_req.wr_data;
				end
			end
			default:
				next_flags = CMD_RD | CMD_NACK | CMD_STO;
		endcase
	end

	always_ff @(posedge Clk or negedge Rst_n)
	begin
		if (!Rst_n)
		begin
			state    <= IDLE;
			idx      <= '0;
			is_rd    <= 1'b0;
			ack_err  <= 1'b0;
			done     <= 1'b0;
			dly_cnt  <= '0;
			byte_cmd <= '0;
		end
		else
		begin
			byte_cmd.go <= 1'b0;
			done        <= 1'b0;
			case (state)
				IDLE:
				begin
					if (xfer_req.wr_start || xfer_req.rd_start)
					begin
						is_rd   <= !xfer_req.wr_start;
						idx     <= '0;
						ack_err <= 1'b0;
						state   <= ISSUE;
					end
				end
				ISSUE:
				begin
					byte_cmd.go    <= 1'b1;
					byte_cmd.flags <= next_flags;
					byte_cmd.tx    <= next_tx;
					state          <= WAIT_BYTE;
				end
				WAIT_BYTE:
				begin
					if (byte_rsp.done)
					begin
						if (idx != 3'd4) // the read byte has no slave ack
							ack_err <= ack_err | byte_rsp.ack_err;
						if (last_byte)
							state <= FINISH;
						else
						begin
							if (idx == 3'd0 && !xfer_req.addr_mode)
								idx <= 3'd2; // low address byte only
							else
								idx <= idx + 3'd1;
							state <= ISSUE;
						end
					end
				end
				FINISH:
				begin
					dly_cnt <= '0;
					state   <= WAIT_DLY;
				end
				WAIT_DLY:
				begin
					if (dly_cnt == xfer_req.dly)
					begin
						done  <= 1'b1;
						state <= IDLE;
					end
					else
						dly_cnt <= dly_cnt + 1'b1;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// engine holds rx until the next go
	always_ff @(posedge Clk)
	begin
		if (state == FINISH && is_rd)
			rd_data <= byte_rsp.rx;
	end

	assign xfer_rsp.busy    = (state != IDLE);
	assign xfer_rsp.done    = done;
	assign xfer_rsp.ack_err = ack_err;
	assign xfer_rsp.rd_data = rd_data;

endmodule

//--- project.f
common/i2c_pkg.sv
source/i2c_apb_regs.sv
i2c_control/i2c_control.sv
i2c_control/i2c_bit_shift.sv
source/i2c_master_top.sv
test/tb_clock_gen.sv
test/tb_i2c_slave.sv
test/tb_checker.sv
test/i2c_chk.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f project.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Done: no errors" sim.log; then
	exit 0
fi
exit 1

//--- source/i2c_apb_regs.sv
`timescale 1ns/100ps

module i2c_apb_regs
	import i2c_pkg::*;
(
	input  logic      Clk,
	input  logic      Rst_n,
	input  apb_req_t  apb_req,
	output apb_rsp_t  apb_rsp,
	output xfer_req_t xfer_req,
	input  xfer_rsp_t xfer_rsp
);

	logic      wr_acc;
	logic      access;
	logic      addr_mode_q;
	byte_t     dev_q;
	reg_addr_t addr_q;
	byte_t     wdata_q;
	dly_t      dly_q;
	logic      wr_start_q;
	logic      rd_start_q;
	logic      done_q;
	logic      ack_err_q;
	byte_t     rd_data_q;
	logic      busy;

	assign access = apb_req.psel && apb_req.penable;
	assign wr_acc = access && apb_req.pwrite;

	// a pending start pulse already counts as busy
	assign busy = xfer_rsp.busy || wr_start_q || rd_start_q;

	always_ff @(posedge Clk or negedge Rst_n)
	begin
		if (!Rst_n)
		begin
			addr_mode_q <= 1'b0;
			dev_q       <= '0;
			addr_q      <= '0;
			wdata_q     <= '0;
			dly_q       <= '0;
			wr_start_q  <= 1'b0;
			rd_start_q  <= 1'b0;
		end
		else
		begin
			wr_start_q <= wr_acc && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[0];
			rd_start_q <= wr_acc && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[1];
			if (wr_acc)
			begin
				case (apb_req.paddr)
					REG_CTRL:  addr_mode_q <= apb_req.pwdata[2];
					REG_DEV:   dev_q       <= apb_req.pwdata[7:0];
					REG_ADDR:  addr_q      <= apb_req.pwdata[15:0];
					REG_WDATA: wdata_q     <= apb_req.pwdata[7:0];
					REG_DLY:   dly_q       <= apb_req.pwdata;
					default:   ;
				endcase
			end
		end
	end

	// sticky done, results of the last frame
	always_ff @(posedge Clk or negedge Rst_n)
	begin
		if (!Rst_n)
		begin
			done_q    <= 1'b0;
			ack_err_q <= 1'b0;
		end
		else if ((wr_start_q || rd_start_q) && !xfer_rsp.busy)
			done_q <= 1'b0;
		else if (xfer_rsp.done)
		begin
			done_q    <= 1'b1;
			ack_err_q <= xfer_rsp.ack_err;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (xfer_rsp.done)
			rd_data_q <= xfer_rsp.rd_data;
	end

	always_comb
	begin
		apb_rsp.prdata  = '0;
		apb_rsp.pready  = 1'b1; // no wait states
		apb_rsp.pslverr = 1'b0;
		if (access)
		begin
			case (apb_req.paddr)
				REG_CTRL:   apb_rsp.prdata = {29'd0, addr_mode_q, 2'b00};
				REG_DEV:    apb_rsp.prdata = {24'd0, dev_q};
				REG_ADDR:   apb_rsp.prdata = {16'd0, addr_q};
				REG_WDATA:  apb_rsp.prdata = {24'd0, wdata_q};
				REG_DLY:    apb_rsp.prdata = dly_q;
				REG_STATUS: apb_rsp.prdata = {29'd0, ack_err_q, done_q, busy};
				REG_RDATA:  apb_rsp.prdata = {24'd0, rd_data_q};
				default:    apb_rsp.pslverr = 1'b1;
			endcase
		end
	end

	assign xfer_req.wr_start  = wr_start_q;
	assign xfer_req.rd_start  = rd_start_q;
	assign xfer_req.addr_mode = addr_mode_q;
	assign xfer_req.dev_id    = dev_q;
	assign xfer_req.reg_addr  = addr_q;
	assign xfer_req.wr_data   = wdata_q;
	assign xfer_req.dly       = dly_q;

endmodule

//--- source/i2c_master_top.sv
`timescale 1ns/100ps

module i2c_master_top
	import i2c_pkg::*;
#(
	parameter int SCL_DIV = 4
)
(
	input  logic      Clk,
	input  logic      Rst_n,
	input  apb_req_t  apb_req,
	output apb_rsp_t  apb_rsp,
	output i2c_pins_t pins,
	input  logic      sda_in
);

	xfer_req_t xfer_req;
	xfer_rsp_t xfer_rsp;
	byte_cmd_t byte_cmd;
	byte_rsp_t byte_rsp;

	i2c_apb_regs regs_i (
		.Clk      (Clk),
		.Rst_n    (Rst_n),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.xfer_req (xfer_req),
		.xfer_rsp (xfer_rsp)
	);

	i2c_control control_i (
		.Clk      (Clk),
		.Rst_n    (Rst_n),
		.xfer_req (xfer_req),
		.xfer_rsp (xfer_rsp),
		.byte_cmd (byte_cmd),
		.byte_rsp (byte_rsp)
	);

	i2c_bit_shift #(
		.SCL_DIV (SCL_DIV)
	) bit_shift_i (
		.Clk      (Clk),
		.Rst_n    (Rst_n),
		.byte_cmd (byte_cmd),
		.byte_rsp (byte_rsp),
		.pins     (pins),
		.sda_in   (sda_in)
	);

endmodule

//--- test/i2c_chk.sv
`timescale 1ns/100ps

module i2c_chk (
	input logic Clk,
	input logic Rst_n,
	input logic go,
	input logic done,
	input logic scl,
	input logic sda_oe,
	input logic sda_in,
	input logic start_stop
);

	logic in_prog; // a byte is being shifted

	always_ff @(posedge Clk or negedge Rst_n)
	begin
		if (!Rst_n)
			in_prog <= 1'b0;
		else if (go)
			in_prog <= 1'b1;
		else if (done)
			in_prog <= 1'b0;
	end

	go_idle_only: assert property (@(posedge Clk) disable iff (!Rst_n) in_prog |-> !go)
		else $error("go while a byte is in progress");

	done_one_cycle: assert property (@(posedge Clk) disable iff (!Rst_n) done |=> !done)
		else $error("done longer than one cycle");

	// only the master may move SDA under a high SCL, as start or stop
	sda_stable_high: assert property (@(posedge Clk) disable iff (!Rst_n)
		(scl && $past(scl) && sda_in != $past(sda_in))
		|-> start_stop && sda_oe != $past(sda_oe))
		else $error("SDA changed while SCL high");

endmodule

bind i2c_bit_shift i2c_chk chk_i (
	.Clk        (Clk),
	.Rst_n      (Rst_n),
	.go         (byte_cmd.go),
	.done       (byte_rsp.done),
	.scl        (pins.scl),
	.sda_oe     (pins.sda_oe),
	.sda_in     (sda_in),
	.start_stop ((state == START) || (state == STOP))
);

//--- test/i2c_trace.txt
# op dev mode reg_addr wdata dly exp_rdata exp_ack_err (hex, op W or R)
# slave memory starts as addr ^ 5A, device 0x50 is byte A0
W A0 1 0021 C3 5 00 0
R A0 1 0021 00 5 C3 0
W A0 0 1234 96 0 00 0
R A0 1 0034 00 3 96 0
R A0 0 FF34 00 2 96 0
W A2 1 0010 77 4 00 1
R A0 1 0010 00 1 4A 0
R A2 1 0010 00 0 FF 1
R A0 0 0055 00 7 0F 0
W A0 1 AB55 3C 2 00 0
R A0 0 0055 00 0 3C 0

//--- test/tb_checker.sv
`timescale 1ns/100ps

module tb_checker
	import i2c_pkg::*;
(
	input logic      Clk,
	input logic      Rst_n,
	input apb_req_t  apb_req,
	input apb_rsp_t  apb_rsp,
	input i2c_pins_t pins,
	input logic      exp_valid,
	input apb_data_t exp_data,
	input apb_data_t exp_mask,
	input logic      exp_err
);

	int   value_errs = 0;
	int   other_errs = 0;
	logic reset_seen = 1'b0;

	// sample in the middle of the cycle
	always @(negedge Clk)
	begin
		if (Rst_n && !reset_seen)
		begin
			reset_seen = 1'b1;
			if (pins.scl !== 1'b1 || pins.sda_oe !== 1'b0)
			begin
				$display("ERROR at %0t: pins after reset scl=%b sda_oe=%b",
					$time, pins.scl, pins.sda_oe);
				value_errs++;
			end
		end
		if (apb_req.psel && apb_req.penable && apb_rsp.pready !== 1'b1)
		begin
			$display("ERROR at %0t: pready low in access to offset %h",
				$time, apb_req.paddr);
			value_errs++;
		end
		if (exp_valid && apb_req.psel && apb_req.penable)
		begin
			if ((apb_rsp.prdata & exp_mask) !== (exp_data & exp_mask) ||
				apb_rsp.pslverr !== exp_err)
			begin
				$display("ERROR at %0t: read of offset %h gave %h err %b, expected %h err %b",
					$time, apb_req.paddr, apb_rsp.prdata & exp_mask, apb_rsp.pslverr,
					exp_data & exp_mask, exp_err);
				value_errs++;
			end
		end
	end

	task automatic note_failure(input string msg);
		$display("%s", msg);
		other_errs++;
	endtask

	function automatic int total_errors();
		return value_errs + other_errs;
	endfunction

	task automatic report();
		$display("checks finished: %0d value errors, %0d other errors",
			value_errs, other_errs);
	endtask

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic Clk,
	output logic Rst_n
);

	initial
	begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk; // 10 ns period
	end

	initial
	begin
		Rst_n = 1'b0;
		repeat (3) @(posedge Clk);
		Rst_n <= 1'b1;
	end

endmodule

//--- test/tb_i2c_slave.sv
`timescale 1ns/100ps

module tb_i2c_slave #(
	parameter logic [6:0] DEV_ADDR = 7'h50
)
(
	input  logic scl,
	input  logic sda,
	input  logic addr_two, // device expects a high address byte first
	output logic sda_drv
);

	typedef enum int {
		S_IDLE,
		S_DEV,
		S_ADDR,
		S_WDATA,
		S_RD_PEND,
		S_READ
	} phase_t;

	logic [7:0] mem [256];
	phase_t     phase;
	logic [7:0] shreg;
	logic [7:0] tx;
	logic [7:0] ptr;
	int         bitn;
	logic       ack_cyc;
	logic       mack;
	logic       got_high;
	logic       scl_q;
	logic       sda_q;

	initial
	begin
		for (int i = 0; i < 256; i++)
			mem[i] = i[7:0] ^ 8'h5A;
		phase    = S_IDLE;
		shreg    = '0;
		tx       = '0;
		ptr      = '0;
		bitn     = 0;
		ack_cyc  = 1'b0;
		mack     = 1'b0;
		got_high = 1'b0;
		sda_drv  = 1'b0;
		scl_q    = 1'b1;
		sda_q    = 1'b1;
	end

	always @(scl or sda)
	begin
		if (scl && scl_q && sda_q && !sda)
		begin
			phase   = S_DEV; // start or repeated start
			bitn    = 0;
			ack_cyc = 1'b0;
			sda_drv = 1'b0;
		end
		else if (scl && scl_q && !sda_q && sda)
		begin
			phase   = S_IDLE; // stop
			ack_cyc = 1'b0;
			sda_drv = 1'b0;
		end
		else if (scl && !scl_q && phase != S_IDLE)
		begin
			if (ack_cyc)
				mack = !sda;
			else
			begin
				if (phase != S_READ)
					shreg = {shreg[6:0], sda};
				bitn = bitn + 1;
			end
		end
		else if (!scl && scl_q && phase != S_IDLE)
		begin
			if (ack_cyc)
			begin
				ack_cyc = 1'b0;
				bitn    = 0;
				sda_drv = 1'b0;
				if (phase == S_RD_PEND)
				begin
					phase   = S_READ;
					tx      = mem[ptr];
					sda_drv = !tx[7];
				end
				else if (phase == S_READ)
				begin
					if (mack)
					begin
						ptr     = ptr + 8'd1;
						tx      = mem[ptr];
						sda_drv = !tx[7];
					end
					else
						phase = S_IDLE; // master sent NACK
				end
			end
			else if (bitn == 8)
			begin
				ack_cyc = 1'b1;
				sda_drv = 1'b0;
				case (phase)
					S_DEV:
					begin
						if (shreg[7:1] == DEV_ADDR)
						begin
							sda_drv  = 1'b1;
							got_high = 1'b0;
							phase    = shreg[0] ? S_RD_PEND : S_ADDR;
						end
						else
							phase = S_IDLE; // not our address
					end
					S_ADDR:
					begin
						sda_drv = 1'b1;
						if (addr_two && !got_high)
							got_high = 1'b1; // high byte unused by the memory
						else
						begin
							ptr   = shreg;
							phase = S_WDATA;
						end
					end
					S_WDATA:
					begin
						sda_drv  = 1'b1;
						mem[ptr] = shreg;
						ptr      = ptr + 8'd1;
					end
					default: ;
				endcase
			end
			else if (phase == S_READ)
				sda_drv = !tx[7 - bitn];
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

//--- test/tb_top.sv
`timescale 1ns/100ps

module tb_top
	import i2c_pkg::*;
;

	localparam int MAX_POLLS = 2000;

	logic      Clk;
	logic      Rst_n;
	apb_req_t  apb_req;
	apb_rsp_t  apb_rsp;
	i2c_pins_t pins;
	logic      sda;
	logic      slave_drv;
	logic      addr_two;
	logic      exp_valid;
	apb_data_t exp_data;
	apb_data_t exp_mask;
	logic      exp_err;

	// wired-AND bus
	assign sda = !(pins.sda_oe || slave_drv);

	tb_clock_gen clk_i (
		.Clk   (Clk),
		.Rst_n (Rst_n)
	);

	i2c_master_top #(
		.SCL_DIV (4)
	) dut_i (
		.Clk     (Clk),
		.Rst_n   (Rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.pins    (pins),
		.sda_in  (sda)
	);

	tb_i2c_slave slave_i (
		.scl      (pins.scl),
		.sda      (sda),
		.addr_two (addr_two),
		.sda_drv  (slave_drv)
	);

	tb_checker checker_i (
		.Clk       (Clk),
		.Rst_n     (Rst_n),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.pins      (pins),
		.exp_valid (exp_valid),
		.exp_data  (exp_data),
		.exp_mask  (exp_mask),
		.exp_err   (exp_err)
	);

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		@(posedge Clk);
		apb_req.paddr   <= addr;
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= 1'b1;
		apb_req.pwdata  <= data;
		@(posedge Clk);
		apb_req.penable <= 1'b1;
		@(posedge Clk);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, input logic check, input apb_data_t exp,
		input apb_data_t mask, input logic err, output apb_data_t data);
		exp_valid = check;
		exp_data  = exp;
		exp_mask  = mask;
		exp_err   = err;
		@(posedge Clk);
		apb_req.paddr   <= addr;
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= 1'b0;
		@(posedge Clk);
		apb_req.penable <= 1'b1;
		@(negedge Clk);
		data = apb_rsp.prdata;
		@(posedge Clk);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
		exp_valid = 1'b0;
	endtask

	task automatic wait_done(output logic ok);
		apb_data_t st;
		ok = 1'b0;
		for (int i = 0; i < MAX_POLLS && !ok; i++)
		begin
			apb_read(REG_STATUS, 1'b0, '0, '0, 1'b0, st);
			if (st[1])
				ok = 1'b1;
		end
	endtask

	initial
	begin
		int        fd;
		int        n;
		int        ops;
		string     line;
		logic [7:0] op;
		apb_data_t dev;
		apb_data_t mode;
		apb_data_t addr;
		apb_data_t wdata;
		apb_data_t dly;
		apb_data_t exp_rd;
		apb_data_t exp_ack;
		apb_data_t rd;
		logic      ok;
		apb_req   = '0;
		addr_two  = 1'b0;
		exp_valid = 1'b0;
		exp_data  = '0;
		exp_mask  = '0;
		exp_err   = 1'b0;
		ops       = 0;
		for (int i = 0; i < 20 && Rst_n !== 1'b1; i++)
			@(posedge Clk);
		if (Rst_n !== 1'b1)
			checker_i.note_failure("reset was never released");
		apb_read(REG_STATUS, 1'b1, '0, 32'hFFFF_FFFF, 1'b0, rd);
		apb_read(8'h20, 1'b1, '0, 32'hFFFF_FFFF, 1'b1, rd); // unmapped
		fd = $fopen("test/i2c_trace.txt", "r");
		if (fd == 0)
			checker_i.note_failure("cannot open test/i2c_trace.txt");
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() == 0 || line[0] == "#")
					continue;
				n = $sscanf(line, "%c %h %h %h %h %h %h %h",
					op, dev, mode, addr, wdata, dly, exp_rd, exp_ack);
				if (n != 8)
					continue;
				ops++;
				addr_two = mode[0];
				apb_write(REG_DEV, dev);
				apb_write(REG_ADDR, addr);
				apb_write(REG_WDATA, wdata);
				apb_write(REG_DLY, dly);
				apb_write(REG_CTRL, {29'd0, mode[0], op == "R", op == "W"});
				apb_read(REG_STATUS, 1'b1, 32'h1, 32'h1, 1'b0, rd); // busy at once
				wait_done(ok);
				if (!ok)
				begin
					checker_i.note_failure("timeout waiting for done");
					continue;
				end
				apb_read(REG_STATUS, 1'b1, {29'd0, exp_ack[0], 2'b10}, 32'h7, 1'b0, rd);
				if (op == "R")
					apb_read(REG_RDATA, 1'b1, exp_rd, 32'hFF, 1'b0, rd);
			end
			$fclose(fd);
			if (ops == 0)
				checker_i.note_failure("trace held no operations");
		end
		checker_i.report();
		if (checker_i.total_errors() == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
